//--- filelist.f
src/rt_result_pkg.sv
src/result_serializer.sv
src/result_bus_arbiter.sv
src/result_receive.sv
src/result_path_top.sv
verification/result_path_properties.sv
verification/result_path_tb.sv

//--- verification/result_path_tb.sv
`timescale 1ns/1ps
`default_nettype none

module result_path_tb import rt_result_pkg::*;
();

    typedef struct packed
    {
        logic [tri_id_width-1:0] id_a;
        logic [tri_id_width-1:0] id_b;
        logic [tri_id_width-1:0] id_c;
        logic hit_a;
        logic hit_b;
        logic hit_c;
        logic [bary_width-1:0] u_a;
        logic [bary_width-1:0] u_b;
        logic [bary_width-1:0] u_c;
        logic [bary_width-1:0] v_a;
        logic [bary_width-1:0] v_b;
        logic [bary_width-1:0] v_c;
    } result_set_t;

    logic clk;
    logic globalreset;
    logic load_01;
    logic load_10;
    logic [tri_id_width-1:0] set_id_a_01, set_id_b_01, set_id_c_01;
    logic set_hit_a_01, set_hit_b_01, set_hit_c_01;
    logic [bary_width-1:0] set_u_a_01, set_u_b_01, set_u_c_01;
    logic [bary_width-1:0] set_v_a_01, set_v_b_01, set_v_c_01;
    logic [tri_id_width-1:0] set_id_a_10, set_id_b_10, set_id_c_10;
    logic set_hit_a_10, set_hit_b_10, set_hit_c_10;
    logic [bary_width-1:0] set_u_a_10, set_u_b_10, set_u_c_10;
    logic [bary_width-1:0] set_v_a_10, set_v_b_10, set_v_c_10;
    logic busy_01;
    logic busy_10;
    logic valid_01;
    logic valid_10;
    logic [tri_id_width-1:0] id_a_01, id_b_01, id_c_01;
    logic hit_a_01, hit_b_01, hit_c_01;
    logic [bary_width-1:0] u_a_01, u_b_01, u_c_01;
    logic [bary_width-1:0] v_a_01, v_b_01, v_c_01;
    logic [tri_id_width-1:0] id_a_10, id_b_10, id_c_10;
    logic hit_a_10, hit_b_10, hit_c_10;
    logic [bary_width-1:0] u_a_10, u_b_10, u_c_10;
    logic [bary_width-1:0] v_a_10, v_b_10, v_c_10;

    logic [31:0] lfsr_state = 32'he66d10ae;
    logic monitor_on = 1'b0;
    int count_01 = 0;
    int count_10 = 0;
    result_set_t expected_01[$];
    result_set_t expected_10[$];
    result_set_t held_01 = '0;
    result_set_t held_10 = '0;
    result_source_e delivery_order[$];

    result_path_top u_result_path_top
    (
        .*
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic result_set_t random_set();
        result_set_t s;
        s.id_a = tri_id_width'(take_bits(tri_id_width));
        s.id_b = tri_id_width'(take_bits(tri_id_width));
        s.id_c = tri_id_width'(take_bits(tri_id_width));
        s.hit_a = 1'(take_bits(1));
        s.hit_b = 1'(take_bits(1));
        s.hit_c = 1'(take_bits(1));
        s.u_a = bary_width'(take_bits(bary_width));
        s.u_b = bary_width'(take_bits(bary_width));
        s.u_c = bary_width'(take_bits(bary_width));
        s.v_a = bary_width'(take_bits(bary_width));
        s.v_b = bary_width'(take_bits(bary_width));
        s.v_c = bary_width'(take_bits(bary_width));
        return s;
    endfunction

    function automatic result_set_t read_outputs(input result_source_e src);
        if (src == src_01)
            return {id_a_01, id_b_01, id_c_01, hit_a_01, hit_b_01, hit_c_01,
                    u_a_01, u_b_01, u_c_01, v_a_01, v_b_01, v_c_01};
        return {id_a_10, id_b_10, id_c_10, hit_a_10, hit_b_10, hit_c_10,
                u_a_10, u_b_10, u_c_10, v_a_10, v_b_10, v_c_10};
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_id(input string name, input logic [tri_id_width-1:0] expected,
                              input logic [tri_id_width-1:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic compare_bary(input string name, input logic [bary_width-1:0] expected,
                                input logic [bary_width-1:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic compare_hit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic compare_source(input string name, input result_source_e expected,
                                  input result_source_e actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_set(input result_source_e src, input result_set_t expected);
        result_set_t actual;
        string sfx;
        actual = read_outputs(src);
        sfx = (src == src_01) ? "_01" : "_10";
        compare_id({"id_a", sfx}, expected.id_a, actual.id_a);
        compare_id({"id_b", sfx}, expected.id_b, actual.id_b);
        compare_id({"id_c", sfx}, expected.id_c, actual.id_c);
        compare_hit({"hit_a", sfx}, expected.hit_a, actual.hit_a);
        compare_hit({"hit_b", sfx}, expected.hit_b, actual.hit_b);
        compare_hit({"hit_c", sfx}, expected.hit_c, actual.hit_c);
        compare_bary({"u_a", sfx}, expected.u_a, actual.u_a);
        compare_bary({"u_b", sfx}, expected.u_b, actual.u_b);
        compare_bary({"u_c", sfx}, expected.u_c, actual.u_c);
        compare_bary({"v_a", sfx}, expected.v_a, actual.v_a);
        compare_bary({"v_b", sfx}, expected.v_b, actual.v_b);
        compare_bary({"v_c", sfx}, expected.v_c, actual.v_c);
    endtask

    // Between pulses each field may only hold or move toward the next queued set
    task automatic watch_source(input result_source_e src, input logic valid);
        result_set_t actual;
        result_set_t held;
        result_set_t next;
        int pending;
        actual = read_outputs(src);
        held = (src == src_01) ? held_01 : held_10;
        pending = (src == src_01) ? expected_01.size() : expected_10.size();
        next = held;
        if (pending > 0)
            next = (src == src_01) ? expected_01[0] : expected_10[0];
        if (valid)
        begin
            if (pending == 0)
                stop_with_failure($sformatf("valid pulsed for source %h with no set loaded", src));
            check_set(src, next);
            delivery_order.push_back(src);
            if (src == src_01)
            begin
                held_01 = expected_01.pop_front();
                count_01++;
            end
            else
            begin
                held_10 = expected_10.pop_front();
                count_10++;
            end
        end
        else if (((actual ^ held) & (actual ^ next)) != '0)
            stop_with_failure($sformatf("fields of source %h changed outside a delivery", src));
    endtask

    always @(posedge clk)
    begin
        if (u_result_path_top.u_receive.u_properties.failure_count != 0)
            stop_with_failure("a bus protocol assertion failed");
        if (monitor_on)
        begin
            watch_source(src_01, valid_01);
            watch_source(src_10, valid_10);
        end
    end

    task automatic drive_set(input result_source_e src, input result_set_t s);
        if (src == src_01)
            {set_id_a_01, set_id_b_01, set_id_c_01, set_hit_a_01, set_hit_b_01, set_hit_c_01,
             set_u_a_01, set_u_b_01, set_u_c_01, set_v_a_01, set_v_b_01, set_v_c_01} <= s;
        else
            {set_id_a_10, set_id_b_10, set_id_c_10, set_hit_a_10, set_hit_b_10, set_hit_c_10,
             set_u_a_10, set_u_b_10, set_u_c_10, set_v_a_10, set_v_b_10, set_v_c_10} <= s;
    endtask

    // Called on a rising edge where the source is known to be idle
    task automatic load_now(input result_source_e src, input result_set_t s);
        drive_set(src, s);
        if (src == src_01)
        begin
            load_01 <= 1'b1;
            expected_01.push_back(s);
        end
        else
        begin
            load_10 <= 1'b1;
            expected_10.push_back(s);
        end
    endtask

    task automatic wait_free(input result_source_e src);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((src == src_01) ? (busy_01 || load_01) : (busy_10 || load_10))
        begin
            if (cycles == 200)
                stop_with_failure($sformatf("source %h stayed busy for 200 cycles", src));
            cycles++;
            @(posedge clk);
        end
    endtask

    task automatic wait_for_delivery(input result_source_e src, input int target);
        int cycles;
        cycles = 0;
        while (((src == src_01) ? count_01 : count_10) < target)
        begin
            if (cycles == 200)
            begin
                if (src == src_01)
                    stop_with_failure("valid_01 never came within 200 cycles");
                else
                    stop_with_failure("valid_10 never came within 200 cycles");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic drain_outstanding();
        while (expected_01.size() > 0)
            wait_for_delivery(src_01, count_01 + 1);
        while (expected_10.size() > 0)
            wait_for_delivery(src_10, count_10 + 1);
        // Quiet window in which a stray pulse would be caught by the monitor
        repeat (10) @(posedge clk);
    endtask

    task automatic verify_reset_values();
        compare_hit("valid_01", 1'b0, valid_01);
        compare_hit("valid_10", 1'b0, valid_10);
        compare_hit("busy_01", 1'b0, busy_01);
        compare_hit("busy_10", 1'b0, busy_10);
        check_set(src_01, '0);
        check_set(src_10, '0);
    endtask

    task automatic single_source_delivery(input result_source_e src);
        wait_free(src);
        load_now(src, random_set());
        @(posedge clk);
        load_01 <= 1'b0;
        load_10 <= 1'b0;
        drain_outstanding();
    endtask

    task automatic simultaneous_pair_delivery(input result_source_e first,
                                              input result_source_e second);
        delivery_order.delete();
        wait_free(src_01);
        wait_free(src_10);
        load_now(src_01, random_set());
        load_now(src_10, random_set());
        @(posedge clk);
        load_01 <= 1'b0;
        load_10 <= 1'b0;
        drain_outstanding();
        if (delivery_order.size() != 2)
            stop_with_failure($sformatf("pair gave %0d deliveries", delivery_order.size()));
        compare_source("delivery_order[0]", first, delivery_order[0]);
        compare_source("delivery_order[1]", second, delivery_order[1]);
    endtask

    task automatic random_load_traffic();
        int loaded;
        int cycles;
        logic coin;
        loaded = 0;
        cycles = 0;
        while (loaded < 30)
        begin
            @(posedge clk);
            if (cycles == 2000)
                stop_with_failure("random sets were not all loaded within 2000 cycles");
            cycles++;
            load_01 <= 1'b0;
            load_10 <= 1'b0;
            coin = (take_bits(1) != 0);
            if (coin && !busy_01 && !load_01)
            begin
                load_now(src_01, random_set());
                loaded++;
            end
            coin = (take_bits(1) != 0);
            if (coin && !busy_10 && !load_10 && loaded < 30)
            begin
                load_now(src_10, random_set());
                loaded++;
            end
        end
        @(posedge clk);
        load_01 <= 1'b0;
        load_10 <= 1'b0;
        drain_outstanding();
    endtask

    initial
    begin
        globalreset = 1'b1;
        load_01 = 1'b0;
        load_10 = 1'b0;
        drive_set(src_01, '0);
        drive_set(src_10, '0);
        repeat (10) @(posedge clk);
        globalreset <= 1'b0;
        @(posedge clk);
        verify_reset_values();
        monitor_on = 1'b1;
        single_source_delivery(src_01);
        single_source_delivery(src_10);
        simultaneous_pair_delivery(src_01, src_10);
        // Round robin hands the next contested pick to source 10
        simultaneous_pair_delivery(src_10, src_01);
        random_load_traffic();
        if (u_result_path_top.u_receive.u_properties.failure_count == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            stop_with_failure("a bus protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- verification/result_path_properties.sv
`timescale 1ns/1ps
`default_nettype none

module result_path_properties import rt_result_pkg::*;
(
    input wire logic           clk,
    input wire logic           globalreset,
    input wire logic           valid_01,
    input wire logic           valid_10,
    input wire logic           result_ready,
    input wire result_source_e result_source,
    input wire receive_state_e state
);

    int failure_count = 0;

    one_valid_at_a_time: assert property (@(posedge clk) disable iff (globalreset)
        !(valid_01 && valid_10))
    else
    begin
        failure_count++;
        $error("valid_01 and valid_10 are high in the same cycle");
    end

    valid_01_single_cycle: assert property (@(posedge clk) disable iff (globalreset)
        valid_01 |=> !valid_01)
    else
    begin
        failure_count++;
        $error("valid_01 stayed high for more than one cycle");
    end

    valid_10_single_cycle: assert property (@(posedge clk) disable iff (globalreset)
        valid_10 |=> !valid_10)
    else
    begin
        failure_count++;
        $error("valid_10 stayed high for more than one cycle");
    end

    ready_has_source: assert property (@(posedge clk) disable iff (globalreset)
        result_ready |-> (result_source != src_none))
    else
    begin
        failure_count++;
        $error("result_ready is high with the idle source code");
    end

    idle_without_ready: assert property (@(posedge clk) disable iff (globalreset)
        (state == rx_idle && !result_ready) |=> (state == rx_idle))
    else
    begin
        failure_count++;
        $error("receiver left idle without result_ready");
    end

    // A burst occupies the receiver for exactly one burst length
    burst_length: assert property (@(posedge clk) disable iff (globalreset)
        (state == rx_idle && result_ready) |=> ##(burst_words - 1) (state == rx_idle))
    else
    begin
        failure_count++;
        $error("receiver did not return to idle after a full burst");
    end

endmodule

bind result_receive result_path_properties u_properties
(
    .clk(clk),
    .globalreset(globalreset),
    .valid_01(valid_01),
    .valid_10(valid_10),
    .result_ready(result_ready),
    .result_source(result_source),
    .state(state)
);

`default_nettype wire

//--- src/result_path_top.sv
`timescale 1ns/1ps
`default_nettype none

module result_path_top import rt_result_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          globalreset,
    input  wire logic                          load_01,
    input  wire logic                          load_10,
    input  wire logic [tri_id_width-1:0]       set_id_a_01, set_id_b_01, set_id_c_01,
    input  wire logic                          set_hit_a_01, set_hit_b_01, set_hit_c_01,
    input  wire logic [bary_width-1:0]         set_u_a_01, set_u_b_01, set_u_c_01,
    input  wire logic [bary_width-1:0]         set_v_a_01, set_v_b_01, set_v_c_01,
    input  wire logic [tri_id_width-1:0]       set_id_a_10, set_id_b_10, set_id_c_10,
    input  wire logic                          set_hit_a_10, set_hit_b_10, set_hit_c_10,
    input  wire logic [bary_width-1:0]         set_u_a_10, set_u_b_10, set_u_c_10,
    input  wire logic [bary_width-1:0]         set_v_a_10, set_v_b_10, set_v_c_10,
    output logic                               busy_01,
    output logic                               busy_10,
    output logic                               valid_01,
    output logic                               valid_10,
    output logic [tri_id_width-1:0]            id_a_01, id_b_01, id_c_01,
    output logic                               hit_a_01, hit_b_01, hit_c_01,
    output logic [bary_width-1:0]              u_a_01, u_b_01, u_c_01,
    output logic [bary_width-1:0]              v_a_01, v_b_01, v_c_01,
    output logic [tri_id_width-1:0]            id_a_10, id_b_10, id_c_10,
    output logic                               hit_a_10, hit_b_10, hit_c_10,
    output logic [bary_width-1:0]              u_a_10, u_b_10, u_c_10,
    output logic [bary_width-1:0]              v_a_10, v_b_10, v_c_10
);

    logic req_01;
    logic req_10;
    logic grant_01;
    logic grant_10;
    logic last_01;
    logic last_10;
    logic [result_word_width-1:0] word_01;
    logic [result_word_width-1:0] word_10;
    logic [result_word_width-1:0] result_data;
    logic result_ready;
    result_source_e result_source;

    result_serializer u_ser_01
    (
        .clk(clk), .globalreset(globalreset), .load(load_01),
        .id_a(set_id_a_01), .id_b(set_id_b_01), .id_c(set_id_c_01),
        .hit_a(set_hit_a_01), .hit_b(set_hit_b_01), .hit_c(set_hit_c_01),
        .u_a(set_u_a_01), .u_b(set_u_b_01), .u_c(set_u_c_01),
        .v_a(set_v_a_01), .v_b(set_v_b_01), .v_c(set_v_c_01),
        .grant(grant_01), .req(req_01), .busy(busy_01),
        .word(word_01), .last(last_01)
    );

    result_serializer u_ser_10
    (
        .clk(clk), .globalreset(globalreset), .load(load_10),
        .id_a(set_id_a_10), .id_b(set_id_b_10), .id_c(set_id_c_10),
        .hit_a(set_hit_a_10), .hit_b(set_hit_b_10), .hit_c(set_hit_c_10),
        .u_a(set_u_a_10), .u_b(set_u_b_10), .u_c(set_u_c_10),
        .v_a(set_v_a_10), .v_b(set_v_b_10), .v_c(set_v_c_10),
        .grant(grant_10), .req(req_10), .busy(busy_10),
        .word(word_10), .last(last_10)
    );

    result_bus_arbiter u_arbiter
    (
        .clk(clk), .globalreset(globalreset),
        .req_01(req_01), .req_10(req_10),
        .word_01(word_01), .word_10(word_10),
        .last_01(last_01), .last_10(last_10),
        .grant_01(grant_01), .grant_10(grant_10),
        .result_data(result_data),
        .result_ready(result_ready),
        .result_source(result_source)
    );

    // Receiver port names match the top level nets one to one
    result_receive u_receive
    (
        .*
    );

endmodule

`default_nettype wire

//--- src/result_receive.sv
`timescale 1ns/1ps
`default_nettype none

module result_receive import rt_result_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          globalreset,
    input  wire logic [result_word_width-1:0]  result_data,
    input  wire logic                          result_ready,
    input  wire result_source_e                result_source,
    output logic                               valid_01,
    output logic                               valid_10,
    output logic [tri_id_width-1:0]            id_a_01, id_b_01, id_c_01,
    output logic                               hit_a_01, hit_b_01, hit_c_01,
    output logic [bary_width-1:0]              u_a_01, u_b_01, u_c_01,
    output logic [bary_width-1:0]              v_a_01, v_b_01, v_c_01,
    output logic [tri_id_width-1:0]            id_a_10, id_b_10, id_c_10,
    output logic                               hit_a_10, hit_b_10, hit_c_10,
    output logic [bary_width-1:0]              u_a_10, u_b_10, u_c_10,
    output logic [bary_width-1:0]              v_a_10, v_b_10, v_c_10
);

    receive_state_e state;
    receive_state_e next_state;
    logic start_01;
    logic start_10;

    assign start_01 = result_ready && (result_source == src_01);
    assign start_10 = result_ready && (result_source == src_10);

    always_comb
    begin
        case (state)
            rx_idle:
            begin
                if (start_01)
                    next_state = rx_hit_01;
                else if (start_10)
                    next_state = rx_hit_10;
                else
                    next_state = rx_idle;
            end
            rx_hit_01: next_state = rx_u_01;
            rx_u_01:   next_state = rx_v_01;
            rx_hit_10: next_state = rx_u_10;
            rx_u_10:   next_state = rx_v_10;
            default:   next_state = rx_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            state <= rx_idle;
            valid_01 <= 1'b0;
            valid_10 <= 1'b0;
            id_a_01 <= '0;
            id_b_01 <= '0;
            id_c_01 <= '0;
            hit_a_01 <= 1'b0;
            hit_b_01 <= 1'b0;
            hit_c_01 <= 1'b0;
            u_a_01 <= '0;
            u_b_01 <= '0;
            u_c_01 <= '0;
            v_a_01 <= '0;
            v_b_01 <= '0;
            v_c_01 <= '0;
            id_a_10 <= '0;
            id_b_10 <= '0;
            id_c_10 <= '0;
            hit_a_10 <= 1'b0;
            hit_b_10 <= 1'b0;
            hit_c_10 <= 1'b0;
            u_a_10 <= '0;
            u_b_10 <= '0;
            u_c_10 <= '0;
            v_a_10 <= '0;
            v_b_10 <= '0;
            v_c_10 <= '0;
        end
        else
        begin
            state <= next_state;
            // Pulse follows the fourth word of the burst
            valid_01 <= (state == rx_v_01);
            valid_10 <= (state == rx_v_10);
            case (state)
                rx_idle:
                begin
                    if (start_01)
                    begin
                        id_a_01 <= result_data[31:16];
                        id_b_01 <= result_data[15:0];
                    end
                    else if (start_10)
                    begin
                        id_a_10 <= result_data[31:16];
                        id_b_10 <= result_data[15:0];
                    end
                end
                rx_hit_01:
                begin
                    hit_a_01 <= result_data[18];
                    hit_b_01 <= result_data[17];
                    hit_c_01 <= result_data[16];
                    id_c_01 <= result_data[15:0];
                end
                rx_u_01:
                begin
                    u_a_01 <= result_data[23:16];
                    u_b_01 <= result_data[15:8];
                    u_c_01 <= result_data[7:0];
                end
                rx_v_01:
                begin
                    v_a_01 <= result_data[23:16];
                    v_b_01 <= result_data[15:8];
                    v_c_01 <= result_data[7:0];
                end
                rx_hit_10:
                begin
                    hit_a_10 <= result_data[18];
                    hit_b_10 <= result_data[17];
                    hit_c_10 <= result_data[16];
                    id_c_10 <= result_data[15:0];
                end
                rx_u_10:
                begin
                    u_a_10 <= result_data[23:16];
                    u_b_10 <= result_data[15:8];
                    u_c_10 <= result_data[7:0];
                end
                rx_v_10:
                begin
                    v_a_10 <= result_data[23:16];
                    v_b_10 <= result_data[15:8];
                    v_c_10 <= result_data[7:0];
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/result_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module result_bus_arbiter import rt_result_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          globalreset,
    input  wire logic                          req_01,
    input  wire logic                          req_10,
    input  wire logic [result_word_width-1:0]  word_01,
    input  wire logic [result_word_width-1:0]  word_10,
    input  wire logic                          last_01,
    input  wire logic                          last_10,
    output logic                               grant_01,
    output logic                               grant_10,
    output logic [result_word_width-1:0]       result_data,
    output logic                               result_ready,
    output result_source_e                     result_source
);

    result_source_e owner;
    logic first;
    logic last_served_10;
    logic owner_free;

    assign grant_01 = (owner == src_01);
    assign grant_10 = (owner == src_10);

    // Bus is free when idle or when the owner is on its final word
    assign owner_free = (owner == src_none) || (grant_01 && last_01) || (grant_10 && last_10);

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            owner <= src_none;
            first <= 1'b0;
            last_served_10 <= 1'b1;
        end
        else
        begin
            first <= 1'b0;
            if (owner_free)
            begin
                if (req_01 && req_10)
                begin
                    // Priority only moves on a contested pick
                    owner <= last_served_10 ? src_01 : src_10;
                    last_served_10 <= !last_served_10;
                    first <= 1'b1;
                end
                else if (req_01 || req_10)
                begin
                    owner <= req_01 ? src_01 : src_10;
                    first <= 1'b1;
                end
                else
                begin
                    owner <= src_none;
                end
            end
        end
    end

    // The bus is registered, one cycle behind the serializer word
    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            result_ready <= 1'b0;
            result_source <= src_none;
        end
        else
        begin
            result_ready <= first;
            result_source <= first ? owner : src_none;
        end
    end

    always_ff @(posedge clk)
    begin
        result_data <= grant_10 ? word_10 : (grant_01 ? word_01 : '0);
    end

endmodule

`default_nettype wire

//--- src/result_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module result_serializer import rt_result_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          globalreset,
    input  wire logic                          load,
    input  wire logic [tri_id_width-1:0]       id_a,
    input  wire logic [tri_id_width-1:0]       id_b,
    input  wire logic [tri_id_width-1:0]       id_c,
    input  wire logic                          hit_a,
    input  wire logic                          hit_b,
    input  wire logic                          hit_c,
    input  wire logic [bary_width-1:0]         u_a,
    input  wire logic [bary_width-1:0]         u_b,
    input  wire logic [bary_width-1:0]         u_c,
    input  wire logic [bary_width-1:0]         v_a,
    input  wire logic [bary_width-1:0]         v_b,
    input  wire logic [bary_width-1:0]         v_c,
    input  wire logic                          grant,
    output logic                               req,
    output logic                               busy,
    output logic [result_word_width-1:0]       word,
    output logic                               last
);

    logic [1:0] beat;
    logic [tri_id_width-1:0] id_a_q;
    logic [tri_id_width-1:0] id_b_q;
    logic [tri_id_width-1:0] id_c_q;
    logic [2:0] hit_q;
    logic [3*bary_width-1:0] u_q;
    logic [3*bary_width-1:0] v_q;

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            busy <= 1'b0;
            beat <= 2'd0;
        end
        else if (!busy)
        begin
            busy <= load;
            beat <= 2'd0;
        end
        else if (grant)
        begin
            if (last)
            begin
                busy <= 1'b0;
                beat <= 2'd0;
            end
            else
            begin
                beat <= beat + 2'd1;
            end
        end
    end

    // Loads arriving during a burst are dropped
    always_ff @(posedge clk)
    begin
        if (load && !busy)
        begin
            id_a_q <= id_a;
            id_b_q <= id_b;
            id_c_q <= id_c;
            hit_q <= {hit_a, hit_b, hit_c};
            u_q <= {u_a, u_b, u_c};
            v_q <= {v_a, v_b, v_c};
        end
    end

    // The beat index only reaches the final word while granted
    assign last = busy && (beat == 2'(burst_words - 1));

    // Request drops during the last word so the arbiter can hand over at once
    assign req = busy && !last;

    always_comb
    begin
        case (beat)
            2'd0:    word = {id_a_q, id_b_q};
            2'd1:    word = {13'd0, hit_q, id_c_q};
            2'd2:    word = {8'd0, u_q};
            default: word = {8'd0, v_q};
        endcase
    end

endmodule

`default_nettype wire

//--- src/rt_result_pkg.sv
`default_nettype none

package rt_result_pkg;

    // Bus format widths
    localparam int result_word_width = 32;
    localparam int tri_id_width = 16;
    localparam int bary_width = 8;
    localparam int burst_words = 4;

    // Source code carried with the first word of a burst
    typedef enum logic [1:0]
    {
        src_none = 2'b00,
        src_01 = 2'b01,
        src_10 = 2'b10
    } result_source_e;

    // Words 2 to 4 of each burst have their own state per source
    typedef enum logic [2:0]
    {
        rx_idle = 3'd0,
        rx_hit_01 = 3'd1,
        rx_u_01 = 3'd2,
        rx_v_01 = 3'd3,
        rx_hit_10 = 3'd4,
        rx_u_10 = 3'd5,
        rx_v_10 = 3'd6
    } receive_state_e;

endpackage

`default_nettype wire
